// ==== list.f ====
+incdir+testbench
hdl/memory_game_pkg.sv
hdl/game_step_fsm.sv
hdl/pick_history.sv
hdl/card_view_reg.sv
hdl/memory_game_top.sv
testbench/memory_game_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# builds the testbench with Verilator and runs it from the project root.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ns \
	-f list.f --top-module memory_game_tb -o memory_game_sim

result=$(./obj_dir/memory_game_sim)
echo "$result"

if echo "$result" | grep -qx "Verification passed"; then
	exit 0
else
	exit 1
fi

// ==== testbench/memory_game_model.svh ====
`ifndef MEMORY_GAME_MODEL_SVH
`define MEMORY_GAME_MODEL_SVH

// sels holds sel4..sel1 and pairs holds pair3..pair1, three bits per pick, first pick lowest.
function automatic memory_game_pkg::card_view_vec_t expected_views(
	input memory_game_pkg::step_t step_in,
	input logic [11:0]            sels,
	input logic [11:0]            pairs,
	input logic                   over
);
	memory_game_pkg::card_view_vec_t views;
	int   rnd;
	int   ph;
	logic earlier;
	logic chosen;
	logic partner;

	rnd = int'(step_in) / STEPS_PER_ROUND;
	ph  = int'(step_in) % STEPS_PER_ROUND;
	for (int c = 0; c < CARDS; c++) begin
		if (over) begin
			views[c] = memory_game_pkg::VIEW_MATCHED;
		end else begin
			earlier = 1'b0;
			for (int r = 0; r < rnd; r++) begin
				if (int'(sels[3*r +: 3]) == c || int'(pairs[3*r +: 3]) == c)
					earlier = 1'b1; // found in a finished round.
			end
			chosen = (int'(sels[3*rnd +: 3]) == c);
			if (rnd == LAST_ROUND)
				partner = !earlier && !chosen; // the card nobody named yet.
			else
				partner = (int'(pairs[3*rnd +: 3]) == c);
			if (chosen)
				views[c] = (ph == 0) ? memory_game_pkg::VIEW_CURSOR : memory_game_pkg::VIEW_OPEN;
			else if (earlier)
				views[c] = memory_game_pkg::VIEW_MATCHED;
			else if (partner && ph == 1)
				views[c] = memory_game_pkg::VIEW_CURSOR;
			else if (partner && ph == 2)
				views[c] = memory_game_pkg::VIEW_OPEN;
			else
				views[c] = memory_game_pkg::VIEW_HIDDEN;
		end
	end
	return views;
endfunction

`endif

// ==== testbench/memory_game_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module memory_game_tb;

	localparam int CARDS           = 8;
	localparam int STEPS_PER_ROUND = 3;
	localparam int LAST_ROUND      = 3;
	localparam int CYCLE_LIMIT     = 2000; // about 560 cycles of tests plus margin.
	localparam int RANDOM_STEPS    = 500;
	localparam logic [31:0] RAND_SEED = 32'h4c8e;
	localparam memory_game_pkg::step_t WIN_STEP = 4'd12;

	logic                            clk25MHz;
	logic                            rst_n;
	memory_game_pkg::step_t          step;
	memory_game_pkg::card_idx_t      sel1, sel2, sel3, sel4;
	memory_game_pkg::card_idx_t      pair1, pair2, pair3;
	memory_game_pkg::card_view_vec_t card_view;
	logic                            winscreen;

	memory_game_pkg::card_view_vec_t exp_views;
	memory_game_pkg::card_view_vec_t exp_v;
	logic                            exp_w;
	logic                            win_seen  = 1'b0;
	logic                            smp_valid = 1'b0;
	logic [2:0]                      deck [CARDS];
	int                              errors = 0;
	int                              checks = 0;
	int                              tests  = 0;
	int                              err_mark;

	`include "memory_game_model.svh"

	memory_game_top u_dut (
		.clk25MHz  (clk25MHz),
		.rst_n     (rst_n),
		.step      (step),
		.sel1      (sel1),
		.sel2      (sel2),
		.sel3      (sel3),
		.sel4      (sel4),
		.pair1     (pair1),
		.pair2     (pair2),
		.pair3     (pair3),
		.card_view (card_view),
		.winscreen (winscreen)
	);

	initial begin
		clk25MHz = 1'b0;
		forever #20 clk25MHz = ~clk25MHz;
	end

	// ********************
	// reference and compare
	// ********************

	always @(posedge clk25MHz or negedge rst_n) begin
		if (!rst_n) begin
			win_seen  <= 1'b0;
			smp_valid <= 1'b0;
		end else begin
			exp_views <= expected_views(step, {sel4, sel3, sel2, sel1},
				{3'd0, pair3, pair2, pair1}, win_seen || (step >= WIN_STEP));
			if (step >= WIN_STEP)
				win_seen <= 1'b1;
			smp_valid <= 1'b1;
		end
	end

	// the win level rises on the same edge as the matched views.
	always @(negedge clk25MHz) begin
		exp_v = smp_valid ? exp_views : '0; // all hidden.
		exp_w = win_seen;
		checks++;
		assert (card_view === exp_v && winscreen === exp_w) else begin
			errors++;
			$display("ERROR %0t ns: views %h win %b, expected views %h win %b",
				$time, card_view, winscreen, exp_v, exp_w);
		end
	end

	// ********************
	// stimulus
	// ********************

	// picks are packed as pair3, pair2, pair1, sel4, sel3, sel2, sel1 from the top.
	task automatic drive(input memory_game_pkg::step_t s, input logic [20:0] picks);
		@(posedge clk25MHz);
		step  <= s;
		sel1  <= picks[2:0];
		sel2  <= picks[5:3];
		sel3  <= picks[8:6];
		sel4  <= picks[11:9];
		pair1 <= picks[14:12];
		pair2 <= picks[17:15];
		pair3 <= picks[20:18];
	endtask

	task automatic pulse_reset();
		@(posedge clk25MHz);
		rst_n <= 1'b0;
		step  <= '0;
		repeat (3) @(posedge clk25MHz);
		rst_n <= 1'b1;
	endtask

	task automatic shuffle_deck();
		int         j;
		logic [2:0] tmp;
		for (int i = 0; i < CARDS; i++)
			deck[i] = 3'(i);
		for (int i = CARDS - 1; i > 0; i--) begin
			j = int'($urandom_range(i, 0));
			tmp = deck[i];
			deck[i] = deck[j];
			deck[j] = tmp;
		end
	endtask

	function automatic logic [20:0] deck_picks();
		return {deck[5], deck[3], deck[1], deck[6], deck[4], deck[2], deck[0]};
	endfunction

	function automatic logic [20:0] held_picks();
		return {pair3, pair2, pair1, sel4, sel3, sel2, sel1};
	endfunction

	task automatic finish_test(input string name);
		repeat (2) @(posedge clk25MHz); // let the last step reach the compare.
		tests++;
		$display("test %0d %s: %0d errors", tests, name, errors - err_mark);
		err_mark = errors;
	endtask

	initial begin
		void'($urandom(RAND_SEED));
		err_mark = 0;
		rst_n <= 1'b0;
		step  <= '0;
		sel1  <= '0;
		sel2  <= '0;
		sel3  <= '0;
		sel4  <= '0;
		pair1 <= '0;
		pair2 <= '0;
		pair3 <= '0;
		repeat (3) @(posedge clk25MHz);
		rst_n <= 1'b1;
		finish_test("reset state");

		shuffle_deck();
		for (int s = 0; s < 12; s++)
			drive(4'(s), deck_picks());
		finish_test("full game");

		drive(4'd12, held_picks());
		drive(4'd0, held_picks());
		drive(4'd4, held_picks());
		drive(4'd0, held_picks());
		finish_test("sticky win");

		pulse_reset();
		repeat (RANDOM_STEPS)
			drive(4'($urandom_range(11, 0)), 21'($urandom));
		finish_test("random steps");

		shuffle_deck();
		for (int s = 0; s < 8; s++)
			drive(4'(s), deck_picks());
		drive(4'd12, deck_picks());
		pulse_reset();
		finish_test("reset mid game");

		$display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
		if (errors == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

	initial begin : watchdog
		int cycles;
		cycles = 0;
		while (cycles < CYCLE_LIMIT) begin
			@(posedge clk25MHz);
			cycles++;
		end
		$display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
		$display("Verification failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== hdl/memory_game_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module memory_game_top (
	input  wire                                 clk25MHz,
	input  wire                                 rst_n,
	input  wire memory_game_pkg::step_t         step,
	input  wire memory_game_pkg::card_idx_t     sel1,
	input  wire memory_game_pkg::card_idx_t     sel2,
	input  wire memory_game_pkg::card_idx_t     sel3,
	input  wire memory_game_pkg::card_idx_t     sel4,
	input  wire memory_game_pkg::card_idx_t     pair1,
	input  wire memory_game_pkg::card_idx_t     pair2,
	input  wire memory_game_pkg::card_idx_t     pair3,
	output wire memory_game_pkg::card_view_vec_t card_view,
	output wire                                 winscreen
);

	memory_game_pkg::round_t     round;
	memory_game_pkg::phase_t     phase;
	memory_game_pkg::card_mask_t sel_mask;
	memory_game_pkg::card_mask_t partner_mask;
	memory_game_pkg::card_mask_t matched_mask;
	logic                        game_over;
	logic                        win_q;

	game_step_fsm u_step_fsm (
		.clk25MHz  (clk25MHz),
		.rst_n     (rst_n),
		.step      (step),
		.round     (round),
		.phase     (phase),
		.game_over (game_over)
	);

	pick_history u_pick_history (
		.round        (round),
		.phase        (phase),
		.sel1         (sel1),
		.sel2         (sel2),
		.sel3         (sel3),
		.sel4         (sel4),
		.pair1        (pair1),
		.pair2        (pair2),
		.pair3        (pair3),
		.sel_mask     (sel_mask),
		.partner_mask (partner_mask),
		.matched_mask (matched_mask)
	);

	card_view_reg u_card_view (
		.clk25MHz     (clk25MHz),
		.rst_n        (rst_n),
		.sel_mask     (sel_mask),
		.partner_mask (partner_mask),
		.matched_mask (matched_mask),
		.phase        (phase),
		.game_over    (game_over),
		.card_view    (card_view)
	);

	// registered so the win level shows on the same edge as the views.
	always_ff @(posedge clk25MHz or negedge rst_n) begin
		if (!rst_n)
			win_q <= 1'b0;
		else
			win_q <= game_over;
	end

	assign winscreen = win_q; // win level for the display.

endmodule

`default_nettype wire

// ==== hdl/card_view_reg.sv ====
`timescale 1ns/1ns
`default_nettype none

module card_view_reg (
	input  wire                              clk25MHz,
	input  wire                              rst_n,
	input  wire memory_game_pkg::card_mask_t sel_mask,
	input  wire memory_game_pkg::card_mask_t partner_mask,
	input  wire memory_game_pkg::card_mask_t matched_mask,
	input  wire memory_game_pkg::phase_t     phase,
	input  wire                              game_over,
	output memory_game_pkg::card_view_vec_t  card_view
);

	memory_game_pkg::card_view_vec_t view_next;

	// ********************
	// per-card priority
	// ********************

	always_comb begin
		for (int c = 0; c < memory_game_pkg::NUM_CARDS; c++) begin
			if (game_over) begin
				view_next[c] = memory_game_pkg::VIEW_MATCHED;
			end else if (sel_mask[c]) begin
				if (phase == memory_game_pkg::PH_SELECT)
					view_next[c] = memory_game_pkg::VIEW_CURSOR;
				else
					view_next[c] = memory_game_pkg::VIEW_OPEN;
			end else if (matched_mask[c]) begin
				view_next[c] = memory_game_pkg::VIEW_MATCHED;
			end else if (partner_mask[c]) begin
				case (phase)
					memory_game_pkg::PH_PARTNER: view_next[c] = memory_game_pkg::VIEW_CURSOR;
					memory_game_pkg::PH_REVEAL:  view_next[c] = memory_game_pkg::VIEW_OPEN;
					default:                     view_next[c] = memory_game_pkg::VIEW_HIDDEN;
				endcase
			end else begin
				view_next[c] = memory_game_pkg::VIEW_HIDDEN; // not touched yet.
			end
		end
	end

	always_ff @(posedge clk25MHz or negedge rst_n) begin
		if (!rst_n) begin
			for (int c = 0; c < memory_game_pkg::NUM_CARDS; c++)
				card_view[c] <= memory_game_pkg::VIEW_HIDDEN;
		end else begin
			card_view <= view_next;
		end
	end

	// matched is all ones, so the whole vector is set when every card is matched.
	win_shows_matched: assert property (
		@(posedge clk25MHz) disable iff (!rst_n)
		game_over |=> (&card_view)
	);

endmodule

`default_nettype wire

// ==== hdl/pick_history.sv ====
`timescale 1ns/1ns
`default_nettype none

module pick_history (
	input  wire memory_game_pkg::round_t    round,
	input  wire memory_game_pkg::phase_t    phase,
	input  wire memory_game_pkg::card_idx_t sel1,
	input  wire memory_game_pkg::card_idx_t sel2,
	input  wire memory_game_pkg::card_idx_t sel3,
	input  wire memory_game_pkg::card_idx_t sel4,
	input  wire memory_game_pkg::card_idx_t pair1,
	input  wire memory_game_pkg::card_idx_t pair2,
	input  wire memory_game_pkg::card_idx_t pair3,
	output memory_game_pkg::card_mask_t     sel_mask,
	output memory_game_pkg::card_mask_t     partner_mask,
	output memory_game_pkg::card_mask_t     matched_mask
);

	memory_game_pkg::card_mask_t sel_hot  [memory_game_pkg::NUM_ROUNDS];
	memory_game_pkg::card_mask_t pair_hot [memory_game_pkg::NUM_ROUNDS-1];

	function automatic memory_game_pkg::card_mask_t one_hot(
		input memory_game_pkg::card_idx_t idx
	);
		one_hot = memory_game_pkg::card_mask_t'(1) << idx;
	endfunction

	// ********************
	// pick decode
	// ********************

	assign sel_hot[0]  = one_hot(sel1);
	assign sel_hot[1]  = one_hot(sel2);
	assign sel_hot[2]  = one_hot(sel3);
	assign sel_hot[3]  = one_hot(sel4);
	assign pair_hot[0] = one_hot(pair1);
	assign pair_hot[1] = one_hot(pair2);
	assign pair_hot[2] = one_hot(pair3);

	assign sel_mask = sel_hot[round];

	// every pick of a round before the current one.
	always_comb begin
		matched_mask = '0;
		for (int r = 0; r < memory_game_pkg::NUM_ROUNDS - 1; r++) begin
			if (r < int'(round))
				matched_mask |= sel_hot[r] | pair_hot[r];
		end
	end

	always_comb begin
		partner_mask = '0;
		if (phase != memory_game_pkg::PH_SELECT) begin
			if (round == memory_game_pkg::round_t'(memory_game_pkg::NUM_ROUNDS - 1)) begin
				// the last partner is whatever card is still left on the board.
				partner_mask = ~(matched_mask | sel_hot[memory_game_pkg::NUM_ROUNDS-1]);
			end else begin
				for (int r = 0; r < memory_game_pkg::NUM_ROUNDS - 1; r++) begin
					if (r == int'(round))
						partner_mask = pair_hot[r];
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== hdl/game_step_fsm.sv ====
`timescale 1ns/1ns
`default_nettype none

module game_step_fsm (
	input  wire                     clk25MHz,
	input  wire                     rst_n,
	input  wire memory_game_pkg::step_t step,
	output memory_game_pkg::round_t round,
	output memory_game_pkg::phase_t phase,
	output logic                    game_over
);

	typedef enum logic {
		ST_PLAYING,
		ST_WON
	} state_t;

	state_t state;
	state_t state_next;

	// ********************
	// step decode
	// ********************

	always_comb begin
		round = memory_game_pkg::round_t'(step / memory_game_pkg::STEPS_PER_ROUND);
		phase = memory_game_pkg::phase_t'(step % memory_game_pkg::STEPS_PER_ROUND);
	end

	// ********************
	// game-over state
	// ********************

	always_comb begin
		state_next = state;
		case (state)
			ST_PLAYING: begin
				if (step >= memory_game_pkg::WIN_STEP)
					state_next = ST_WON; // the final step has arrived.
			end
			ST_WON:     state_next = ST_WON; // only reset leaves this state.
			default:    state_next = ST_PLAYING;
		endcase
	end

	always_ff @(posedge clk25MHz or negedge rst_n) begin
		if (!rst_n)
			state <= ST_PLAYING;
		else
			state <= state_next;
	end

	// high while won and also on the step that ends the game, so the view
	// register and the win flag move together on that same edge.
	assign game_over = (state_next == ST_WON);

	// the win level is sticky until reset.
	game_over_sticky: assert property (
		@(posedge clk25MHz) disable iff (!rst_n)
		game_over |=> game_over
	);

endmodule

`default_nettype wire

// ==== hdl/memory_game_pkg.sv ====
`default_nettype none

package memory_game_pkg;

	// ********************
	// board and game size
	// ********************

	localparam int NUM_CARDS       = 8;
	localparam int NUM_ROUNDS      = 4;
	localparam int STEPS_PER_ROUND = 3;

	typedef logic [2:0]           card_idx_t;  // position of one card on the board.
	typedef logic [NUM_CARDS-1:0] card_mask_t; // one bit per card.
	typedef logic [3:0]           step_t;
	typedef logic [1:0]           round_t;

	// steps from here on mean the game is over.
	localparam step_t WIN_STEP = step_t'(NUM_ROUNDS * STEPS_PER_ROUND);

	// ********************
	// phases and views
	// ********************

	typedef enum logic [1:0] {
		PH_SELECT,
		PH_PARTNER,
		PH_REVEAL
	} phase_t;

	typedef enum logic [1:0] {
		VIEW_HIDDEN  = 2'd0,
		VIEW_CURSOR  = 2'd1,
		VIEW_OPEN    = 2'd2,
		VIEW_MATCHED = 2'd3
	} card_view_t;

	// card 0 sits in the lowest two bits.
	typedef card_view_t [NUM_CARDS-1:0] card_view_vec_t;

endpackage

`default_nettype wire
